//--- Makefile
TOP := tb_rf_pg

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-Mdir obj_dir -f project.f
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx 'RESULT: PASS'

clean:
	rm -rf obj_dir

//--- logic/rf_array.sv
// Four entry storage array with one write port and one read port
// Data columns have no reset, the valid column clears on reset and
// on every edge while the array is unpowered

`timescale 1ns/1ps

module rf_array
    import rf_types_pkg::*;
(
     input  logic     wclk
    ,input  logic     rclk
    ,input  logic     rst

    ,input  logic     powered

    // Write port from the write stage
    ,input  logic     wr_en
    ,input  rf_addr_t wr_addr
    ,input  rf_cell_t wr_cell

    // Read port driven straight from the outside
    ,input  logic     re
    ,input  rf_addr_t raddr

    ,output rf_cell_t rd_cell
);

    // Data columns and the spare column kept apart so only valid resets
    rf_data_t            mem_data [RF_DEPTH];
    logic [RF_DEPTH-1:0] mem_vld;

    rf_data_t rd_data;
    logic     rd_vld;

    // -------------------------------------------------------------------
    // Write side
    // -------------------------------------------------------------------

    always_ff @(posedge wclk) begin
        if (wr_en) begin
            mem_data[wr_addr] <= wr_cell[RF_DATA_W-1:0];
        end
    end

    // Losing power loses the contents, so every entry becomes empty
    always_ff @(posedge wclk) begin
        if (rst || !powered) begin
            mem_vld <= '0;
        end else if (wr_en) begin
            mem_vld[wr_addr] <= wr_cell[RF_CELL_W-1];
        end
    end

    // -------------------------------------------------------------------
    // Read side
    // -------------------------------------------------------------------

    // Output holds the last captured cell until the next read
    always_ff @(posedge rclk) begin
        if (re) begin
            rd_data <= mem_data[raddr];
        end
    end

    always_ff @(posedge rclk) begin
        if (rst) begin
            rd_vld <= 1'b0;
        end else if (re) begin
            rd_vld <= mem_vld[raddr];
        end
    end

    assign rd_cell = {rd_vld, rd_data};

endmodule

//--- logic/rf_pg_top.sv
// Power gated 4x179 register file
// Joins the wake sequencer, write stage, storage array and read stage
// and passes the wake delay down to the sequencer

`timescale 1ns/1ps

module rf_pg_top
    import rf_types_pkg::*, rf_power_pkg::*;
#(
    parameter int unsigned WAKE_CYCLES = RF_WAKE_CYCLES_DEF
) (
    // Write side
     input  logic     wclk
    ,input  logic     we
    ,input  rf_addr_t waddr
    ,input  rf_data_t wdata

    // Read side
    ,input  logic     rclk
    ,input  logic     re
    ,input  rf_addr_t raddr
    ,output rf_data_t rdata

    // Power interface
    ,input  logic     pwr_enable_b_in
    ,output logic     pwr_enable_b_out
    ,input  logic     pgcb_isol_en

    ,input  logic     rst
);

    // -------------------------------------------------------------------
    // Internal wires
    // -------------------------------------------------------------------

    logic     powered;

    logic     wr_en;
    rf_addr_t wr_addr;
    rf_cell_t wr_cell;

    rf_cell_t rd_cell;

    // Sequencer runs on the read clock, both clocks share one source
    rf_power_ctl #(
        .WAKE_CYCLES (WAKE_CYCLES)
    ) i_power_ctl (
         .rclk             (rclk)
        ,.rst              (rst)
        ,.pwr_enable_b_in  (pwr_enable_b_in)
        ,.powered          (powered)
        ,.pwr_enable_b_out (pwr_enable_b_out)
    );

    rf_write_stage i_write_stage (
         .wclk    (wclk)
        ,.rst     (rst)
        ,.powered (powered)
        ,.we      (we)
        ,.waddr   (waddr)
        ,.wdata   (wdata)
        ,.wr_en   (wr_en)
        ,.wr_addr (wr_addr)
        ,.wr_cell (wr_cell)
    );

    // Read request bypasses any staging and goes straight to the array
    rf_array i_array (
         .wclk    (wclk)
        ,.rclk    (rclk)
        ,.rst     (rst)
        ,.powered (powered)
        ,.wr_en   (wr_en)
        ,.wr_addr (wr_addr)
        ,.wr_cell (wr_cell)
        ,.re      (re)
        ,.raddr   (raddr)
        ,.rd_cell (rd_cell)
    );

    rf_read_stage i_read_stage (
         .rclk         (rclk)
        ,.rst          (rst)
        ,.pgcb_isol_en (pgcb_isol_en)
        ,.rd_cell      (rd_cell)
        ,.rdata        (rdata)
    );

endmodule

//--- logic/rf_power_ctl.sv
// Power gate wake sequencer for the register file
// Tracks the power request, waits out the wake delay and reports
// readiness as a powered level and an active low enable output

`timescale 1ns/1ps

module rf_power_ctl
    import rf_power_pkg::*;
#(
    // Cycles spent in WAKING, must be at least one
    parameter int unsigned WAKE_CYCLES = RF_WAKE_CYCLES_DEF
) (
     input  logic rclk
    ,input  logic rst

    // Active low power request from the power controller
    ,input  logic pwr_enable_b_in

    ,output logic powered
    ,output logic pwr_enable_b_out
);

    // Counter only has to reach WAKE_CYCLES-1
    localparam int CNT_W = (WAKE_CYCLES > 1) ? $clog2(WAKE_CYCLES) : 1;

    pwr_state_t state;
    pwr_state_t state_nxt;

    logic [CNT_W-1:0] wake_cnt;
    logic             wake_done;

    // Last WAKING cycle, the next edge moves to ON
    assign wake_done = (wake_cnt == CNT_W'(WAKE_CYCLES - 1));

    // -------------------------------------------------------------------
    // Next state
    // -------------------------------------------------------------------

    always_comb begin
        state_nxt = state;
        // A released request wins over everything else
        if (pwr_enable_b_in) begin
            state_nxt = PWR_OFF;
        end else begin
            case (state)
                PWR_OFF:    state_nxt = PWR_WAKING;
                PWR_WAKING: state_nxt = wake_done ? PWR_ON : PWR_WAKING;
                PWR_ON:     state_nxt = PWR_ON;
                default:    state_nxt = PWR_OFF;
            endcase
        end
    end

    // -------------------------------------------------------------------
    // State and wake counter
    // -------------------------------------------------------------------

    always_ff @(posedge rclk) begin
        if (rst) begin
            state    <= PWR_OFF;
            wake_cnt <= '0;
        end else begin
            state <= state_nxt;
            // Counter restarts every time WAKING is entered
            if (state != PWR_WAKING) begin
                wake_cnt <= '0;
            end else if (!wake_done) begin
                wake_cnt <= wake_cnt + 1'b1;
            end
        end
    end

    // Array is usable only once the sequence has completed
    assign powered          = (state == PWR_ON);
    assign pwr_enable_b_out = ~powered;

    // Enable output falls only after exactly WAKE_CYCLES cycles in WAKING,
    // entered straight from OFF
    a_enable_only_after_wake : assert property (
        @(posedge rclk) disable iff (rst)
        $fell(pwr_enable_b_out) |->
            $past(state == PWR_WAKING, WAKE_CYCLES) &&
            $past(state == PWR_OFF, WAKE_CYCLES + 1)
    );

endmodule

//--- logic/rf_power_pkg.sv
// Power gating definitions for the register file
// Wake sequencer state encoding and the default wake delay

package rf_power_pkg;

    // -------------------------------------------------------------------
    // Sequencer states
    // -------------------------------------------------------------------

    // OFF holds the array gated, WAKING waits for the rails to settle,
    // ON is the only state where the array may be used
    typedef enum logic [1:0] {
        PWR_OFF    = 2'd0,
        PWR_WAKING = 2'd1,
        PWR_ON     = 2'd2
    } pwr_state_t;

    // -------------------------------------------------------------------
    // Wake timing
    // -------------------------------------------------------------------

    // Number of cycles spent in WAKING before the array reports ready
    localparam int unsigned RF_WAKE_CYCLES_DEF = 6;

endpackage

//--- logic/rf_read_stage.sv
// Read output stage
// Registers the captured cell, returns zero for an empty entry and
// clamps the output while isolation is asserted

`timescale 1ns/1ps

module rf_read_stage
    import rf_types_pkg::*;
(
     input  logic     rclk
    ,input  logic     rst

    // Isolation request from the power gate controller
    ,input  logic     pgcb_isol_en

    // Cell captured by the array on the previous read
    ,input  rf_cell_t rd_cell

    ,output rf_data_t rdata
);

    rf_data_t rdata_q;
    rf_data_t rd_masked;

    // -------------------------------------------------------------------
    // Empty entry mask
    // -------------------------------------------------------------------

    // Data columns of an empty entry are undefined, so they never leave
    assign rd_masked = rd_cell[RF_CELL_W-1] ? rd_cell[RF_DATA_W-1:0] : '0;

    // -------------------------------------------------------------------
    // Output register
    // -------------------------------------------------------------------

    // Loaded every edge, which gives the second cycle of read latency
    always_ff @(posedge rclk) begin
        if (rst) begin
            rdata_q <= '0;
        end else begin
            rdata_q <= rd_masked;
        end
    end

    // -------------------------------------------------------------------
    // Isolation clamp
    // -------------------------------------------------------------------

    // Clamp sits after the register so the held value returns
    // as soon as isolation drops
    assign rdata = pgcb_isol_en ? '0 : rdata_q;

    // A cell captured empty shows as zero one cycle later, isolated or not
    a_isol_clamp : assert property (
        @(posedge rclk) disable iff (rst)
        !$past(rd_cell[RF_CELL_W-1]) |-> (rdata == '0)
    );

endmodule

//--- logic/rf_types_pkg.sv
// Geometry of the 4x179 register file
// Data, address and stored cell widths with their vector typedefs
// The stored cell carries one spare column used as the entry valid flag

package rf_types_pkg;

    // -------------------------------------------------------------------
    // Geometry constants
    // -------------------------------------------------------------------

    // User data width as seen on wdata and rdata
    localparam int RF_DATA_W = 179;

    // Physical column count, one wider than the data for the valid flag
    localparam int RF_CELL_W = RF_DATA_W + 1;

    // Number of entries and the address width that selects one
    localparam int RF_DEPTH  = 4;
    localparam int RF_ADDR_W = $clog2(RF_DEPTH);

    // -------------------------------------------------------------------
    // Vector types
    // -------------------------------------------------------------------

    typedef logic [RF_DATA_W-1:0] rf_data_t;

    // Top bit is the valid column, the rest is the data word
    typedef logic [RF_CELL_W-1:0] rf_cell_t;

    typedef logic [RF_ADDR_W-1:0] rf_addr_t;

endpackage

//--- logic/rf_write_stage.sv
// Write port register stage
// Samples the write strobe, address and data, drops requests while the
// array is unpowered and builds the stored cell with its valid column

`timescale 1ns/1ps

module rf_write_stage
    import rf_types_pkg::*;
(
     input  logic     wclk
    ,input  logic     rst

    // Level from the wake sequencer
    ,input  logic     powered

    // Write request as seen on the outside port
    ,input  logic     we
    ,input  rf_addr_t waddr
    ,input  rf_data_t wdata

    // Registered request toward the array
    ,output logic     wr_en
    ,output rf_addr_t wr_addr
    ,output rf_cell_t wr_cell
);

    // -------------------------------------------------------------------
    // Strobe register
    // -------------------------------------------------------------------

    // A write seen while the array is gated never reaches the array
    always_ff @(posedge wclk) begin
        if (rst) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= we & powered;
        end
    end

    // -------------------------------------------------------------------
    // Address and cell register
    // -------------------------------------------------------------------

    // Payload follows the strobe and is only looked at when wr_en is set
    always_ff @(posedge wclk) begin
        if (we) begin
            wr_addr <= waddr;
            // Valid column sits above the data word
            wr_cell <= {1'b1, wdata};
        end
    end

    // Strobe follows a powered sample and carries the payload taken with it
    a_no_write_unpowered : assert property (
        @(posedge wclk) disable iff (rst)
        wr_en |-> $past(powered) && (wr_addr == $past(waddr)) &&
            (wr_cell == {1'b1, $past(wdata)})
    );

endmodule

//--- project.f
logic/rf_types_pkg.sv
logic/rf_power_pkg.sv
logic/rf_power_ctl.sv
logic/rf_write_stage.sv
logic/rf_array.sv
logic/rf_read_stage.sv
logic/rf_pg_top.sv
sim/tb_rf_pg.sv

//--- sim/tb_rf_pg.sv
// Testbench for the power gated 4x179 register file
// Table of operations with a reference model that fills the expected values
// LFSR write data, one compare task, cycle limit and closing summary

`timescale 1ns/1ps

module tb_rf_pg
    import rf_types_pkg::*, rf_power_pkg::*;
();

    localparam int unsigned WAKE_CYCLES = RF_WAKE_CYCLES_DEF;

    // Alternating word used where a row does not draw random data
    localparam rf_data_t FIXED_WORD = {{89{2'b01}}, 1'b1};

    // -------------------------------------------------------------------
    // Stimulus table
    // -------------------------------------------------------------------

    typedef enum logic [2:0] {
        OP_WRITE, OP_READ, OP_PWR_OFF, OP_PWR_ON, OP_ISO_ON, OP_ISO_OFF, OP_WAIT
    } op_t;

    // Data and exp are filled by the model before the run starts
    typedef struct packed {
        op_t      op;
        rf_addr_t addr;
        logic     rnd;
        rf_data_t data;
        rf_data_t exp;
    } row_t;

    row_t rows[$];

    logic     clk;
    logic     rst;
    logic     we;
    rf_addr_t waddr;
    rf_data_t wdata;
    logic     re;
    rf_addr_t raddr;
    rf_data_t rdata;
    logic     pwr_enable_b_in;
    logic     pwr_enable_b_out;
    logic     pgcb_isol_en;

    logic [31:0] lfsr_state = 32'd89044;
    int          checks = 0;
    int          errors = 0;
    int          cycles = 0;
    int          cycle_limit = 0;

    // Both clock domains come from the same source
    rf_pg_top #(
        .WAKE_CYCLES (WAKE_CYCLES)
    ) i_dut (
         .wclk             (clk)
        ,.we               (we)
        ,.waddr            (waddr)
        ,.wdata            (wdata)
        ,.rclk             (clk)
        ,.re               (re)
        ,.raddr            (raddr)
        ,.rdata            (rdata)
        ,.pwr_enable_b_in  (pwr_enable_b_in)
        ,.pwr_enable_b_out (pwr_enable_b_out)
        ,.pgcb_isol_en     (pgcb_isol_en)
        ,.rst              (rst)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // -------------------------------------------------------------------
    // Helpers
    // -------------------------------------------------------------------

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // One LFSR step per data bit
    function automatic rf_data_t draw_word();
        rf_data_t w;
        for (int b = 0; b < RF_DATA_W; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w[b] = lfsr_state[0];
        end
        return w;
    endfunction

    function automatic string op_name(input op_t op);
        case (op)
            OP_WRITE:   return "write";
            OP_READ:    return "read";
            OP_PWR_OFF: return "power off";
            OP_PWR_ON:  return "power on";
            OP_ISO_ON:  return "isolate on";
            OP_ISO_OFF: return "isolate off";
            default:    return "wait";
        endcase
    endfunction

    // Clock edges each operation takes in apply_row
    function automatic int row_cycles(input op_t op);
        case (op)
            OP_READ:    return 3;
            OP_PWR_OFF: return 3;
            OP_PWR_ON:  return int'(WAKE_CYCLES) + 2;
            default:    return 1;
        endcase
    endfunction

    task automatic check(input string name, input rf_data_t exp, input rf_data_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error: %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic add_row(input op_t op, input int addr, input logic rnd);
        row_t r;
        r      = '0;
        r.op   = op;
        r.addr = rf_addr_t'(addr);
        r.rnd  = rnd;
        rows.push_back(r);
    endtask

    task automatic end_run();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    // -------------------------------------------------------------------
    // Table contents and reference model
    // -------------------------------------------------------------------

    task automatic build_table();
        add_row(OP_PWR_ON, 0, 0);
        // Entry 3 has never been written
        add_row(OP_READ, 3, 0);
        for (int a = 0; a < RF_DEPTH; a++) begin
            add_row(OP_WRITE, a, 1);
        end
        // Read back in a shuffled order
        add_row(OP_READ, 2, 0);
        add_row(OP_READ, 0, 0);
        add_row(OP_READ, 3, 0);
        add_row(OP_READ, 1, 0);
        // A read one cycle after the write still sees the old word
        add_row(OP_WRITE, 2, 1);
        add_row(OP_READ, 2, 0);
        add_row(OP_READ, 2, 0);
        add_row(OP_ISO_ON, 0, 0);
        add_row(OP_WAIT, 0, 0);
        add_row(OP_ISO_OFF, 0, 0);
        add_row(OP_WRITE, 1, 0);
        add_row(OP_WAIT, 0, 0);
        add_row(OP_READ, 1, 0);
        // Power cycle empties every entry
        add_row(OP_PWR_OFF, 0, 0);
        add_row(OP_PWR_ON, 0, 0);
        for (int a = 0; a < RF_DEPTH; a++) begin
            add_row(OP_READ, a, 0);
        end
        // Writes while gated are dropped
        add_row(OP_PWR_OFF, 0, 0);
        add_row(OP_WRITE, 0, 1);
        add_row(OP_WRITE, 3, 1);
        add_row(OP_PWR_ON, 0, 0);
        add_row(OP_READ, 0, 0);
        add_row(OP_READ, 3, 0);
        add_row(OP_WRITE, 3, 1);
        add_row(OP_WAIT, 0, 0);
        add_row(OP_READ, 3, 0);
        add_row(OP_READ, 0, 0);
    endtask

    // Walks the table once, drawing write data and predicting each result
    task automatic build_expected();
        rf_data_t mem [RF_DEPTH];
        logic     vld [RF_DEPTH];
        logic     pwr;
        logic     pend;
        rf_addr_t pend_addr;
        rf_data_t pend_data;
        rf_data_t last;
        pwr       = 1'b0;
        pend      = 1'b0;
        pend_addr = '0;
        pend_data = '0;
        last      = '0;
        for (int a = 0; a < RF_DEPTH; a++) begin
            mem[a] = '0;
            vld[a] = 1'b0;
        end
        foreach (rows[i]) begin
            // Results are taken before the previous row's write lands
            if (rows[i].op == OP_READ) begin
                rows[i].exp = vld[rows[i].addr] ? mem[rows[i].addr] : '0;
                last        = rows[i].exp;
            end else if (rows[i].op == OP_ISO_OFF) begin
                rows[i].exp = last;
            end
            if (pend) begin
                mem[pend_addr] = pend_data;
                vld[pend_addr] = 1'b1;
                pend           = 1'b0;
            end
            case (rows[i].op)
                OP_WRITE: begin
                    rows[i].data = rows[i].rnd ? draw_word() : FIXED_WORD;
                    // Only a write sampled while powered is stored
                    pend      = pwr;
                    pend_addr = rows[i].addr;
                    pend_data = rows[i].data;
                end
                OP_PWR_OFF: begin
                    pwr = 1'b0;
                    for (int a = 0; a < RF_DEPTH; a++) begin
                        vld[a] = 1'b0;
                    end
                end
                OP_PWR_ON: begin
                    pwr = 1'b1;
                    // Write issued in the last wake cycle is sampled gated and never stored
                    rows[i].data = FIXED_WORD;
                end
                default: ;
            endcase
        end
    endtask

    // -------------------------------------------------------------------
    // Row driver
    // -------------------------------------------------------------------

    task automatic apply_row(input int i);
        row_t  r;
        string name;
        int    edges;
        r     = rows[i];
        name  = $sformatf("row %0d %s addr %0d", i, op_name(r.op), r.addr);
        edges = 0;
        @(posedge clk);
        we <= 1'b0;
        re <= 1'b0;
        case (r.op)
            OP_WRITE: begin
                we    <= 1'b1;
                waddr <= r.addr;
                wdata <= r.data;
            end
            OP_READ: begin
                re    <= 1'b1;
                raddr <= r.addr;
                @(posedge clk);
                re <= 1'b0;
                @(posedge clk);
                @(negedge clk);
                check(name, r.exp, rdata);
            end
            OP_PWR_OFF: begin
                pwr_enable_b_in <= 1'b1;
                repeat (2) @(posedge clk);
                @(negedge clk);
                check(name, rf_data_t'(1), rf_data_t'(pwr_enable_b_out));
            end
            OP_PWR_ON: begin
                pwr_enable_b_in <= 1'b0;
                // Count edges until the enable output reports ready
                do begin
                    @(posedge clk);
                    edges++;
                    // A write is sampled on the last gated edge, just before ON
                    we    <= (edges == int'(WAKE_CYCLES));
                    waddr <= r.addr;
                    wdata <= r.data;
                    @(negedge clk);
                end while (pwr_enable_b_out);
                check({name, " wake edges"}, rf_data_t'(WAKE_CYCLES + 1), rf_data_t'(edges));
            end
            OP_ISO_ON: begin
                pgcb_isol_en <= 1'b1;
                @(negedge clk);
                check(name, '0, rdata);
            end
            OP_ISO_OFF: begin
                pgcb_isol_en <= 1'b0;
                @(negedge clk);
                check(name, r.exp, rdata);
            end
            default: ;
        endcase
    endtask

    // -------------------------------------------------------------------
    // Main sequence and cycle limit
    // -------------------------------------------------------------------

    initial begin
        rst             = 1'b1;
        we              = 1'b0;
        waddr           = '0;
        wdata           = '0;
        re              = 1'b0;
        raddr           = '0;
        pwr_enable_b_in = 1'b1;
        pgcb_isol_en    = 1'b0;
        build_table();
        build_expected();
        // Twice the length of reset plus every row
        cycle_limit = 16;
        foreach (rows[i]) begin
            cycle_limit += row_cycles(rows[i].op);
        end
        cycle_limit = 2 * cycle_limit;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check("after reset enable out", rf_data_t'(1), rf_data_t'(pwr_enable_b_out));
        check("after reset rdata", '0, rdata);
        foreach (rows[i]) begin
            apply_row(i);
        end
        @(posedge clk);
        we <= 1'b0;
        re <= 1'b0;
        repeat (2) @(posedge clk);
        end_run();
    end

    initial begin
        while (cycle_limit == 0 || cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        errors++;
        end_run();
    end

endmodule
